/* project.f */
design/cache_pkg.sv
design/fifo_queue.sv
design/bank_arbiter.sv
design/tag_store.sv
design/data_store.sv
design/miss_table.sv
design/cache_bank.sv
tb/cache_bank_tb.sv

/* run.sh */
#!/bin/sh
# Build the cache bank testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module cache_bank_tb -f project.f \
    && ./obj_dir/Vcache_bank_tb | tee sim.log
grep -q "Simulation finished: PASS" sim.log || exit 1

/* tb/cache_bank_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_bank_tb;

    import cache_pkg::*;

    localparam int    CLK_PERIOD = 4;
    localparam int    MSHR_SIZE  = 4;
    localparam int    ID_W       = 2;
    localparam int    MEM_WORDS  = 256;
    localparam int    MAX_ENTRIES = 256;
    localparam int    DRAIN_CYCLES = 200;
    localparam int    WREC_W     = LINE_ADDR_W + WSEL_W + WORD_BYTES + WORD_W;
    localparam word_t PATTERN    = 32'h3c5a_9e00;

    logic            clk;
    logic            rst_n;
    logic            core_req_valid;
    logic            core_req_ready;
    logic            core_req_rw;
    addr_t           core_req_addr;
    byteen_t         core_req_byteen;
    word_t           core_req_data;
    core_tag_t       core_req_tag;
    logic            core_rsp_valid;
    logic            core_rsp_ready;
    word_t           core_rsp_data;
    core_tag_t       core_rsp_tag;
    logic            mem_req_valid;
    logic            mem_req_ready;
    logic            mem_req_rw;
    line_addr_t      mem_req_addr;
    logic [ID_W-1:0] mem_req_id;
    wsel_t           mem_req_wsel;
    byteen_t         mem_req_byteen;
    word_t           mem_req_data;
    logic            mem_rsp_valid;
    logic            mem_rsp_ready;
    logic [ID_W-1:0] mem_rsp_id;
    line_t           mem_rsp_data;

    // Stimulus table
    string   entry_name   [MAX_ENTRIES];
    logic    entry_rw     [MAX_ENTRIES];
    addr_t   entry_addr   [MAX_ENTRIES];
    byteen_t entry_byteen [MAX_ENTRIES];
    word_t   entry_data   [MAX_ENTRIES];
    logic    entry_miss   [MAX_ENTRIES];
    logic    entry_sync   [MAX_ENTRIES];
    int      num_entries;

    word_t             mem_model    [MEM_WORDS];
    word_t             ref_mem      [MEM_WORDS];
    word_t             exp_rsp_data [MAX_ENTRIES];
    logic              rsp_pending  [MAX_ENTRIES];
    int                rsp_outstanding;
    line_addr_t        miss_lines [$];
    logic [WREC_W-1:0] wr_expect [$];
    int                wr_entry [$];

    // Fills waiting in the memory model
    logic [ID_W-1:0] fill_id   [$];
    line_t           fill_line [$];
    int              fill_due  [$];
    int              fill_idx;
    logic            fill_busy;
    int              cycle;
    integer          seed;

    cache_bank #(
        .NUM_LINES  (16),
        .MSHR_SIZE  (MSHR_SIZE),
        .CREQ_DEPTH (2),
        .CRSQ_DEPTH (2),
        .MREQ_DEPTH (4)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_ready  (core_rsp_ready),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_id      (mem_req_id),
        .mem_req_wsel    (mem_req_wsel),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready),
        .mem_rsp_id      (mem_rsp_id),
        .mem_rsp_data    (mem_rsp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic word_t merge_word(input word_t old, input word_t wdata,
                                         input byteen_t be);
        word_t result;
        result = old;
        for (int b = 0; b < WORD_BYTES; b++)
        begin
            if (be[b])
                result[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic line_t read_line(input line_addr_t line);
        line_t result;
        for (int w = 0; w < LINE_WORDS; w++)
            result[w*WORD_W +: WORD_W] = mem_model[(int'(line) * LINE_WORDS + w) % MEM_WORDS];
        return result;
    endfunction

    task automatic add_entry(input string name, input logic rw, input addr_t addr,
                             input byteen_t byteen, input word_t data,
                             input logic miss, input logic sync);
        entry_name[num_entries]   = name;
        entry_rw[num_entries]     = rw;
        entry_addr[num_entries]   = addr;
        entry_byteen[num_entries] = byteen;
        entry_data[num_entries]   = data;
        entry_miss[num_entries]   = miss;
        entry_sync[num_entries]   = sync;
        num_entries++;
    endtask

    // Word addresses; line = addr / 4, cache index = line % 16
    task automatic build_table();
        add_entry("read_miss",        1'b0, 32'h004, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("read_hit",         1'b0, 32'h005, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry("read_hit",         1'b0, 32'h007, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry("write_hit",        1'b1, 32'h006, 4'h3, 32'hcafe_1234, 1'b0, 1'b0);
        add_entry("read_after_write", 1'b0, 32'h006, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry("write_miss",       1'b1, 32'h021, 4'hc, 32'h89ab_cdef, 1'b0, 1'b0);
        add_entry("read_after_wmiss", 1'b0, 32'h021, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("ooo_miss",         1'b0, 32'h008, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("ooo_miss",         1'b0, 32'h00d, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("ooo_miss",         1'b0, 32'h012, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("ooo_miss",         1'b0, 32'h017, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("ooo_miss",         1'b0, 32'h025, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("evict_miss",       1'b0, 32'h044, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("refetch_merged",   1'b0, 32'h006, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("write_evicted",    1'b1, 32'h044, 4'hf, 32'h0bad_f00d, 1'b0, 1'b0);
        add_entry("read_written",     1'b0, 32'h044, 4'h0, 32'h0, 1'b1, 1'b1);
        add_entry("hit_burst",        1'b0, 32'h009, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry("hit_burst",        1'b0, 32'h00e, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry("hit_burst",        1'b0, 32'h013, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry("hit_burst",        1'b0, 32'h016, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry("mixed_miss",       1'b0, 32'h030, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("mixed_hit",        1'b0, 32'h00a, 4'h0, 32'h0, 1'b0, 1'b0);
        add_entry("mixed_miss",       1'b0, 32'h03c, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("mixed_miss",       1'b0, 32'h018, 4'h0, 32'h0, 1'b1, 1'b0);
        add_entry("mixed_hit",        1'b0, 32'h026, 4'h0, 32'h0, 1'b0, 1'b1);
        add_entry("write_byte",       1'b1, 32'h00a, 4'h4, 32'h0077_0000, 1'b0, 1'b0);
        add_entry("read_byte_merged", 1'b0, 32'h00a, 4'h0, 32'h0, 1'b0, 1'b1);
    endtask

    // Drives one entry and records the expectation when it is accepted
    task automatic issue_entry(input int n);
        int         widx;
        line_addr_t line;
        widx            = int'(entry_addr[n]) % MEM_WORDS;
        line            = line_addr_t'(entry_addr[n] >> WSEL_W);
        core_req_valid  = 1'b1;
        core_req_rw     = entry_rw[n];
        core_req_addr   = entry_addr[n];
        core_req_byteen = entry_byteen[n];
        core_req_data   = entry_data[n];
        core_req_tag    = core_tag_t'(n);
        @(negedge clk);
        while (!core_req_ready)
            @(negedge clk);
        if (entry_rw[n])
        begin
            ref_mem[widx] = merge_word(ref_mem[widx], entry_data[n], entry_byteen[n]);
            wr_expect.push_back({line, wsel_t'(entry_addr[n]), entry_byteen[n], entry_data[n]});
            wr_entry.push_back(n);
        end
        else
        begin
            exp_rsp_data[n] = ref_mem[widx];
            rsp_pending[n]  = 1'b1;
            rsp_outstanding++;
            if (entry_miss[n])
                miss_lines.push_back(line);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;
        waited         = 0;
        core_req_valid = 1'b0;
        while ((rsp_outstanding != 0 || wr_expect.size() != 0) && waited < DRAIN_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        assert (miss_lines.size() == 0)
            else abort_run($sformatf("Expected memory read of line %h never came", miss_lines[0]));
        assert (wr_expect.size() == 0)
            else abort_run($sformatf("Memory write for %s never came", entry_name[wr_entry[0]]));
        // Every issued read answered once
        for (int t = 0; t < num_entries; t++)
        begin
            assert (!rsp_pending[t])
                else abort_run($sformatf("Read with tag %0d never got a response", t));
        end
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        seed            = 32'he14a_6959;
        clk             = 1'b0;
        rst_n           = 1'b0;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_id      = '0;
        mem_rsp_data    = '0;
        fill_busy       = 1'b0;
        fill_idx        = 0;
        cycle           = 0;
        rsp_outstanding = 0;
        num_entries     = 0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem_model[i] = PATTERN ^ word_t'(i);
            ref_mem[i]   = PATTERN ^ word_t'(i);
        end
        for (int t = 0; t < MAX_ENTRIES; t++)
            rsp_pending[t] = 1'b0;
        build_table();

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!core_rsp_valid && !mem_req_valid && !mem_rsp_ready)
            else abort_run("Outputs are not idle after reset");

        @(posedge clk);
        #1;
        for (int n = 0; n < num_entries; n++)
        begin
            issue_entry(n);
            if (entry_sync[n])
                drain();
        end
        drain();

        assert (fill_id.size() == 0)
            else abort_run("Memory model still holds fills nobody asked for");
        $display("Simulation finished: PASS");
        $finish;
    end

    // Ready levels and fill presentation, a little after each rising edge
    always @(posedge clk)
    begin
        #1;
        cycle          = cycle + 1;
        core_rsp_ready = ($random(seed) & 3) != 0;
        mem_req_ready  = ($random(seed) & 7) != 0;
        if (!fill_busy)
        begin
            mem_rsp_valid = 1'b0;
            for (int i = 0; i < fill_due.size(); i++)
            begin
                if (!fill_busy && fill_due[i] <= cycle)
                begin
                    fill_busy     = 1'b1;
                    fill_idx      = i;
                    mem_rsp_valid = 1'b1;
                    mem_rsp_id    = fill_id[i];
                    mem_rsp_data  = fill_line[i];
                end
            end
        end
    end

    // Memory side transfers, seen mid-cycle
    always @(negedge clk)
    begin
        int widx;
        int found;
        if (rst_n && mem_req_valid && mem_req_ready)
        begin
            if (mem_req_rw)
            begin
                assert (wr_expect.size() != 0)
                    else abort_run("Memory write request without a matching core write");
                assert ({mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data} == wr_expect[0])
                    else abort_run($sformatf("[ERROR] %s: expected %h, actual %h",
                        entry_name[wr_entry[0]], wr_expect[0],
                        {mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data}));
                widx = (int'(mem_req_addr) * LINE_WORDS + int'(mem_req_wsel)) % MEM_WORDS;
                mem_model[widx] = merge_word(mem_model[widx], mem_req_data, mem_req_byteen);
                wr_expect.pop_front();
                wr_entry.pop_front();
            end
            else
            begin
                found = -1;
                for (int i = 0; i < miss_lines.size(); i++)
                begin
                    if (found < 0 && miss_lines[i] == mem_req_addr)
                        found = i;
                end
                assert (found >= 0)
                    else abort_run($sformatf("Unexpected memory read of line %h", mem_req_addr));
                miss_lines.delete(found);
                fill_id.push_back(mem_req_id);
                fill_line.push_back(read_line(mem_req_addr));
                fill_due.push_back(cycle + 2 + int'({$random(seed)} % 12));
            end
        end
        if (rst_n && mem_rsp_valid && mem_rsp_ready)
        begin
            fill_id.delete(fill_idx);
            fill_line.delete(fill_idx);
            fill_due.delete(fill_idx);
            fill_busy = 1'b0;
        end
    end

    // Core responses matched by tag
    always @(negedge clk)
    begin
        if (rst_n && core_rsp_valid && core_rsp_ready)
        begin
            assert (rsp_pending[core_rsp_tag])
                else abort_run($sformatf("Response with tag %0d that is not outstanding",
                    core_rsp_tag));
            assert (core_rsp_data == exp_rsp_data[core_rsp_tag])
                else abort_run($sformatf("[ERROR] %s: expected %h, actual %h",
                    entry_name[core_rsp_tag], exp_rsp_data[core_rsp_tag], core_rsp_data));
            rsp_pending[core_rsp_tag] = 1'b0;
            rsp_outstanding--;
        end
    end

    initial
    begin
        #1;
        repeat (200 * num_entries) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles with %0d reads still waiting",
            200 * num_entries, rsp_outstanding));
    end

endmodule

`default_nettype wire

/* design/cache_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_bank #(
    parameter  int NUM_LINES  = 16,
    parameter  int MSHR_SIZE  = 4,
    parameter  int CREQ_DEPTH = 2,
    parameter  int CRSQ_DEPTH = 2,
    parameter  int MREQ_DEPTH = 4,
    localparam int ID_W       = (MSHR_SIZE > 1) ? $clog2(MSHR_SIZE) : 1
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        core_req_valid,
    output logic                       core_req_ready,
    input  wire                        core_req_rw,
    input  wire cache_pkg::addr_t      core_req_addr,
    input  wire cache_pkg::byteen_t    core_req_byteen,
    input  wire cache_pkg::word_t      core_req_data,
    input  wire cache_pkg::core_tag_t  core_req_tag,
    output logic                       core_rsp_valid,
    input  wire                        core_rsp_ready,
    output cache_pkg::word_t           core_rsp_data,
    output cache_pkg::core_tag_t       core_rsp_tag,
    output logic                       mem_req_valid,
    input  wire                        mem_req_ready,
    output logic                       mem_req_rw,
    output cache_pkg::line_addr_t      mem_req_addr,
    output logic [ID_W-1:0]            mem_req_id,
    output cache_pkg::wsel_t           mem_req_wsel,
    output cache_pkg::byteen_t         mem_req_byteen,
    output cache_pkg::word_t           mem_req_data,
    input  wire                        mem_rsp_valid,
    output logic                       mem_rsp_ready,
    input  wire [ID_W-1:0]             mem_rsp_id,
    input  wire cache_pkg::line_t      mem_rsp_data
);

    import cache_pkg::*;

    core_req_t creq_in, creq;
    core_rsp_t crsq_in, crsq_out;
    mem_req_t  mreq_in, mreq_out;

    logic creq_full, creq_empty, creq_grant, fill_grant;
    logic crsq_full, crsq_empty, crsq_push;
    logic mreq_empty, mreq_alm_full, mreq_push;
    logic stall, miss_outstanding, credit_return;
    logic read_st0, hit_st0, allocate;
    logic read_st1, rsp_st1;
    logic [ID_W-1:0] alloc_id;
    core_tag_t fill_tag;
    wsel_t     fill_wsel;
    word_t     rdata;

    // Line address of each outstanding miss, for the fill lookup
    line_addr_t miss_addr [MSHR_SIZE];

    logic       valid_st0, fill_st0, write_st0;
    line_addr_t addr_st0;
    wsel_t      wsel_st0;
    byteen_t    byteen_st0;
    word_t      data_st0;
    line_t      line_st0;
    core_tag_t  tag_st0;
    logic [ID_W-1:0] fill_id_st0;

    logic       valid_st1, fill_st1, write_st1, hit_st1;
    line_addr_t addr_st1;
    wsel_t      wsel_st1;
    byteen_t    byteen_st1;
    word_t      data_st1;
    line_t      line_st1;
    core_tag_t  tag_st1;
    logic [ID_W-1:0] id_st1;

    assign creq_in = '{rw: core_req_rw, addr: line_of(core_req_addr),
                       wsel: wsel_of(core_req_addr), byteen: core_req_byteen,
                       data: core_req_data, tag: core_req_tag};
    assign core_req_ready = !creq_full;

    fifo_queue #(.T(core_req_t), .DEPTH(CREQ_DEPTH)) creq_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (core_req_valid && !creq_full),
        .data_in  (creq_in),
        .pop      (creq_grant),
        .data_out (creq),
        .empty    (creq_empty),
        .full     (creq_full),
        .alm_full ()
    );

    bank_arbiter #(.MSHR_SIZE(MSHR_SIZE)) arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .fill_valid       (mem_rsp_valid),
        .creq_valid       (!creq_empty),
        .creq_rw          (creq.rw),
        .stall            (stall),
        .mreq_alm_full    (mreq_alm_full),
        .credit_return    (credit_return),
        .fill_grant       (fill_grant),
        .creq_grant       (creq_grant),
        .miss_outstanding (miss_outstanding)
    );

    assign mem_rsp_ready = miss_outstanding && !stall;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_st0 <= 1'b0;
            fill_st0  <= 1'b0;
            write_st0 <= 1'b0;
            valid_st1 <= 1'b0;
            fill_st1  <= 1'b0;
            write_st1 <= 1'b0;
        end
        else if (!stall)
        begin
            valid_st0 <= fill_grant || creq_grant;
            fill_st0  <= fill_grant;
            write_st0 <= !fill_grant && creq.rw;
            valid_st1 <= valid_st0;
            fill_st1  <= fill_st0;
            write_st1 <= write_st0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            addr_st0    <= fill_grant ? miss_addr[mem_rsp_id] : creq.addr;
            wsel_st0    <= creq.wsel;
            byteen_st0  <= creq.byteen;
            data_st0    <= creq.data;
            line_st0    <= mem_rsp_data;
            tag_st0     <= creq.tag;
            fill_id_st0 <= mem_rsp_id;
            hit_st1     <= hit_st0;
            addr_st1    <= addr_st0;
            wsel_st1    <= wsel_st0;
            byteen_st1  <= byteen_st0;
            data_st1    <= data_st0;
            line_st1    <= line_st0;
            tag_st1     <= tag_st0;
            id_st1      <= fill_st0 ? fill_id_st0 : alloc_id;
        end
        if (allocate)
            miss_addr[alloc_id] <= addr_st0;
    end

    assign read_st0 = valid_st0 && !fill_st0 && !write_st0;
    assign allocate = read_st0 && !stall;

    tag_store #(.NUM_LINES(NUM_LINES)) tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (addr_st0),
        .fill        (valid_st0 && fill_st0),
        .stall       (stall),
        .hit         (hit_st0)
    );

    miss_table #(.MSHR_SIZE(MSHR_SIZE)) mshr (
        .clk            (clk),
        .rst_n          (rst_n),
        .allocate       (allocate),
        .alloc_tag      (tag_st0),
        .alloc_wsel     (wsel_st0),
        .alloc_id       (alloc_id),
        .fill_id        (id_st1),
        .fill_tag       (fill_tag),
        .fill_wsel      (fill_wsel),
        .release_hit    (read_st1 && hit_st1 && !stall),
        .release_hit_id (id_st1),
        .release_fill   (valid_st1 && fill_st1 && !stall)
    );

    data_store #(.NUM_LINES(NUM_LINES)) data (
        .clk       (clk),
        .addr      (addr_st1),
        .wsel      (wsel_st1),
        .byteen    (byteen_st1),
        .wdata     (data_st1),
        .fill_data (line_st1),
        .fill      (valid_st1 && fill_st1),
        .write     (valid_st1 && write_st1 && hit_st1),
        .stall     (stall),
        .rdata     (rdata)
    );

    assign read_st1 = valid_st1 && !fill_st1 && !write_st1;
    assign rsp_st1  = (read_st1 && hit_st1) || (valid_st1 && fill_st1);

    // A response that cannot enter the queue freezes the pipeline
    assign stall         = rsp_st1 && crsq_full;
    assign crsq_push     = rsp_st1 && !stall;
    assign credit_return = crsq_push;

    assign crsq_in = '{data: fill_st1 ? word_of(line_st1, fill_wsel) : rdata,
                       tag:  fill_st1 ? fill_tag : tag_st1};

    fifo_queue #(.T(core_rsp_t), .DEPTH(CRSQ_DEPTH)) crsq_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (crsq_push),
        .data_in  (crsq_in),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_out (crsq_out),
        .empty    (crsq_empty),
        .full     (crsq_full),
        .alm_full ()
    );

    assign core_rsp_valid = !crsq_empty;
    assign core_rsp_data  = crsq_out.data;
    assign core_rsp_tag   = crsq_out.tag;

    // Read misses fetch a line, every write goes through
    assign mreq_push = !stall && ((read_st1 && !hit_st1) || (valid_st1 && write_st1));
    assign mreq_in   = '{rw: write_st1, addr: addr_st1, id: TAG_W'(id_st1), wsel: wsel_st1,
                         byteen: byteen_st1, data: data_st1};

    fifo_queue #(.T(mem_req_t), .DEPTH(MREQ_DEPTH)) mreq_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mreq_push),
        .data_in  (mreq_in),
        .pop      (mem_req_valid && mem_req_ready),
        .data_out (mreq_out),
        .empty    (mreq_empty),
        .full     (),
        .alm_full (mreq_alm_full)
    );

    assign mem_req_valid  = !mreq_empty;
    assign mem_req_rw     = mreq_out.rw;
    assign mem_req_addr   = mreq_out.addr;
    assign mem_req_id     = mreq_out.id[ID_W-1:0];
    assign mem_req_wsel   = mreq_out.wsel;
    assign mem_req_byteen = mreq_out.byteen;
    assign mem_req_data   = mreq_out.data;

endmodule

`default_nettype wire

/* design/miss_table.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_table #(
    parameter  int MSHR_SIZE = 4,
    localparam int ID_W      = (MSHR_SIZE > 1) ? $clog2(MSHR_SIZE) : 1
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       allocate,
    input  wire cache_pkg::core_tag_t alloc_tag,
    input  wire cache_pkg::wsel_t     alloc_wsel,
    output logic [ID_W-1:0]           alloc_id,
    input  wire [ID_W-1:0]            fill_id,
    output cache_pkg::core_tag_t      fill_tag,
    output cache_pkg::wsel_t          fill_wsel,
    input  wire                       release_hit,
    input  wire [ID_W-1:0]            release_hit_id,
    input  wire                       release_fill
);

    import cache_pkg::*;

    logic [MSHR_SIZE-1:0] busy;
    core_tag_t            entry_tag  [MSHR_SIZE];
    wsel_t                entry_wsel [MSHR_SIZE];
    logic                 full;

    assign full = &busy;

    // Lowest free entry
    always_comb
    begin
        alloc_id = '0;
        for (int i = MSHR_SIZE - 1; i >= 0; i--)
        begin
            if (!busy[i])
                alloc_id = ID_W'(i);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy <= '0;
        else
        begin
            if (allocate)
                busy[alloc_id] <= 1'b1;
            if (release_hit)
                busy[release_hit_id] <= 1'b0;
            if (release_fill)
                busy[fill_id] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (allocate)
        begin
            entry_tag[alloc_id]  <= alloc_tag;
            entry_wsel[alloc_id] <= alloc_wsel;
        end
    end

    assign fill_tag  = entry_tag[fill_id];
    assign fill_wsel = entry_wsel[fill_id];

    // Read credits in the arbiter bound the entries in use
    assert property (@(posedge clk) disable iff (!rst_n) allocate |-> !full)
        else $error("miss_table: allocation while full");

endmodule

`default_nettype wire

/* design/data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module data_store #(
    parameter int NUM_LINES = 16
) (
    input  wire                        clk,
    input  wire cache_pkg::line_addr_t addr,
    input  wire cache_pkg::wsel_t      wsel,
    input  wire cache_pkg::byteen_t    byteen,
    input  wire cache_pkg::word_t      wdata,
    input  wire cache_pkg::line_t      fill_data,
    input  wire                        fill,
    input  wire                        write,
    input  wire                        stall,
    output cache_pkg::word_t           rdata
);

    import cache_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);

    line_t            lines [NUM_LINES];
    logic [IDX_W-1:0] idx;

    assign idx   = addr[IDX_W-1:0];
    assign rdata = word_of(lines[idx], wsel);

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if (fill)
                lines[idx] <= fill_data;
            else if (write)
            begin
                // Byte merge into the selected word
                for (int b = 0; b < WORD_BYTES; b++)
                begin
                    if (byteen[b])
                        lines[idx][(int'(wsel) * WORD_BYTES + b) * 8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Write hold-off keeps fills and write hits apart
    assert property (@(posedge clk) !(fill && write))
        else $error("data_store: fill and write in the same cycle");

endmodule

`default_nettype wire

/* design/tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

module tag_store #(
    parameter int NUM_LINES = 16
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cache_pkg::line_addr_t lookup_addr,
    input  wire                   fill,
    input  wire                   stall,
    output logic                  hit
);

    import cache_pkg::*;

    localparam int IDX_W  = $clog2(NUM_LINES);
    localparam int LTAG_W = LINE_ADDR_W - IDX_W;

    logic [NUM_LINES-1:0] line_valid;
    logic [LTAG_W-1:0]    line_tag [NUM_LINES];
    logic [IDX_W-1:0]     idx;
    logic [LTAG_W-1:0]    ltag;

    assign idx  = lookup_addr[IDX_W-1:0];
    assign ltag = lookup_addr[LINE_ADDR_W-1:IDX_W];
    assign hit  = line_valid[idx] && (line_tag[idx] == ltag);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            line_valid <= '0;
        else if (fill && !stall)
            line_valid[idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill && !stall)
            line_tag[idx] <= ltag;
    end

endmodule

`default_nettype wire

/* design/bank_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter #(
    parameter  int MSHR_SIZE = 4,
    localparam int CNT_W     = $clog2(MSHR_SIZE + 1)
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  fill_valid,
    input  wire  creq_valid,
    input  wire  creq_rw,
    input  wire  stall,
    input  wire  mreq_alm_full,
    input  wire  credit_return,
    output logic fill_grant,
    output logic creq_grant,
    output logic miss_outstanding
);

    logic [CNT_W-1:0] credits_used;
    logic             credit_free;
    logic             read_grant;

    // Every read in flight holds a credit, hits included
    assign miss_outstanding = (credits_used != '0);
    assign credit_free      = (credits_used < CNT_W'(MSHR_SIZE));

    // Fills always win
    assign fill_grant = fill_valid && miss_outstanding && !stall;

    // Writes wait until no read is in flight
    assign creq_grant = creq_valid && !fill_grant && !stall && !mreq_alm_full
                      && credit_free && (!creq_rw || !miss_outstanding);

    assign read_grant = creq_grant && !creq_rw;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            credits_used <= '0;
        else if (read_grant && !credit_return)
            credits_used <= credits_used + 1'b1;
        else if (!read_grant && credit_return)
            credits_used <= credits_used - 1'b1;
    end

endmodule

`default_nettype wire

/* design/fifo_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_queue #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  push,
    input  wire  T data_in,
    input  wire  pop,
    output T     data_out,
    output logic empty,
    output logic full,
    output logic alm_full
);

    // DEPTH is a power of two so the extra pointer bit wraps cleanly
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T entries [DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] count;

    assign count    = wr_ptr - rd_ptr;
    assign empty    = (count == '0);
    assign full     = (count == (AW+1)'(DEPTH));
    // Leaves room for two items still in the pipeline
    assign alm_full = (count >= (AW+1)'(DEPTH - 2));
    assign data_out = entries[rd_ptr[AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            entries[wr_ptr[AW-1:0]] <= data_in;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(push && full) && !(pop && empty))
        else $error("fifo_queue: push while full or pop while empty");

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int WORD_BYTES  = WORD_W / 8;
    localparam int LINE_WORDS  = 4;
    localparam int WSEL_W      = $clog2(LINE_WORDS);
    localparam int LINE_W      = LINE_WORDS * WORD_W;
    localparam int LINE_ADDR_W = ADDR_W - WSEL_W;
    localparam int TAG_W       = 8;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [WSEL_W-1:0]      wsel_t;
    typedef logic [WORD_BYTES-1:0]  byteen_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [TAG_W-1:0]       core_tag_t;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    // Id field holds any miss table of up to 256 entries
    typedef struct packed {
        logic             rw;
        line_addr_t       addr;
        logic [TAG_W-1:0] id;
        wsel_t            wsel;
        byteen_t          byteen;
        word_t            data;
    } mem_req_t;

    function automatic line_addr_t line_of(input addr_t addr);
        return addr[ADDR_W-1:WSEL_W];
    endfunction

    function automatic wsel_t wsel_of(input addr_t addr);
        return addr[WSEL_W-1:0];
    endfunction

    function automatic word_t word_of(input line_t line, input wsel_t wsel);
        return line[wsel*WORD_W +: WORD_W];
    endfunction

endpackage

`default_nettype wire
